//--- flist.f
logic/oramPkg.sv
logic/dramPkg.sv
logic/modeSelect.sv
logic/trafficGen.sv
logic/blockCore.sv
logic/tinyOramWrap.sv
test/clockGen.sv
test/dramModel.sv
test/tinyOramTb.sv

//--- test/tinyOramTb.sv
/* Block store testbench
   Host table with a shadow model, then a traffic generator run, then a DRAM sweep */

`timescale 1ns/1ps

module tinyOramTb;

	localparam int NumEntries = 13;
	localparam int NumBlocks = 1024;
	localparam int TimeoutCycles = NumEntries * 60 + oramPkg::TGenBlocks * 2 * 60;

	typedef struct packed {
		logic                           mode;
		oramPkg::cmdE                   cmd;
		logic [oramPkg::ORAMU-1:0]      addr;
		logic [oramPkg::FEDWidth-1:0]   w0;
		logic [oramPkg::FEDWidth-1:0]   w1;
	} stimT;

	logic                               Clock;
	logic                               rstN;
	oramPkg::oramCmd                    hostCmd;
	logic                               hostCmdValid;
	logic                               hostCmdReady;
	logic [oramPkg::FEDWidth-1:0]       hostDataIn;
	logic                               hostDataInValid;
	logic                               hostDataInReady;
	logic [oramPkg::FEDWidth-1:0]       hostDataOut;
	logic                               hostDataOutValid;
	logic                               hostDataOutReady;
	logic                               modeTrafficGen;
	dramPkg::dramCmd                    dramCmdOut;
	logic                               dramCmdValid;
	logic                               dramCmdReady;
	logic [dramPkg::BEDWidth-1:0]       dramReadData;
	logic                               dramReadDataValid;
	dramPkg::dramWrite                  dramWriteOut;
	logic                               dramWriteValid;
	logic                               dramWriteReady;
	logic                               patternDone;
	logic                               patternError;
	logic                               dramStall;

	stimT                               stimTable [NumEntries];
	// Expected block contents by block address
	logic [dramPkg::BEDWidth-1:0]       shadow [NumBlocks];
	logic [15:0]                        lfsrState = 16'd9886;
	int                                 cycleCount = 0;

	clockGen clk (.Clock(Clock), .rstN(rstN));

	dramModel dram (
		.Clock(Clock), .rstN(rstN), .stall(dramStall),
		.cmd(dramCmdOut), .cmdValid(dramCmdValid), .cmdReady(dramCmdReady),
		.readData(dramReadData), .readDataValid(dramReadDataValid),
		.writeIn(dramWriteOut), .writeValid(dramWriteValid), .writeReady(dramWriteReady)
	);

	tinyOramWrap tinyOramWrap_i (
		.Clock(Clock), .rstN(rstN),
		.hostCmd(hostCmd), .hostCmdValid(hostCmdValid), .hostCmdReady(hostCmdReady),
		.hostDataIn(hostDataIn), .hostDataInValid(hostDataInValid),
		.hostDataInReady(hostDataInReady),
		.hostDataOut(hostDataOut), .hostDataOutValid(hostDataOutValid),
		.hostDataOutReady(hostDataOutReady),
		.modeTrafficGen(modeTrafficGen),
		.dramCmdOut(dramCmdOut), .dramCmdValid(dramCmdValid), .dramCmdReady(dramCmdReady),
		.dramReadData(dramReadData), .dramReadDataValid(dramReadDataValid),
		.dramWriteOut(dramWriteOut), .dramWriteValid(dramWriteValid),
		.dramWriteReady(dramWriteReady),
		.patternDone(patternDone), .patternError(patternError)
	);

	// ------------------------------------------------------------------------
	// Random bits and reporting
	// ------------------------------------------------------------------------

	// 16-bit Galois LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One step per bit taken
	function automatic logic [31:0] randomBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
		return r;
	endfunction

	task automatic failRun(input string line);
		$display("%s", line);
		$display("FAIL: see errors above");
		$fatal(1, "run stopped");
	endtask

	task automatic checkWord(input string name, input logic [oramPkg::FEDWidth-1:0] got,
		input logic [oramPkg::FEDWidth-1:0] exp);
		if (got !== exp) begin
			failRun($sformatf("error %s: got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			failRun($sformatf("error %s: got 0x%h expected 0x%h", name, got, exp));
		end
	endtask

	task automatic checkBlock(input int addr, input logic [dramPkg::BEDWidth-1:0] got,
		input logic [dramPkg::BEDWidth-1:0] exp);
		if (got !== exp) begin
			failRun($sformatf("error mem[0x%h]: got 0x%h expected 0x%h", addr, got, exp));
		end
	endtask

	// Generator block with word 1 on top and bit 0 of word k flipped by k
	function automatic logic [dramPkg::BEDWidth-1:0] patternBlock(input int a);
		logic [15:0] upper;
		logic [15:0] lower;
		upper = 16'(a);
		lower = ~upper;
		return {upper, lower ^ 16'd1, upper, lower};
	endfunction

	task automatic setEntry(input int i, input logic mode, input oramPkg::cmdE cmd,
		input logic [oramPkg::ORAMU-1:0] addr);
		stimTable[i].mode = mode;
		stimTable[i].cmd = cmd;
		stimTable[i].addr = addr;
		stimTable[i].w0 = randomBits(32);
		stimTable[i].w1 = randomBits(32);
	endtask

	// ------------------------------------------------------------------------
	// Host and generator sequences
	// ------------------------------------------------------------------------

	// Starts on a rising edge and ends on the edge where the core is idle again
	task automatic hostAccess(input stimT e);
		logic [dramPkg::BEDWidth-1:0] expBlock;
		logic [oramPkg::FEDWidth-1:0] heldWord;
		logic held;
		int idx;
		expBlock = shadow[e.addr];
		held = 1'b0;
		idx = 0;
		hostCmd <= '{cmd: e.cmd, pAddr: e.addr};
		hostCmdValid <= 1'b1;
		do @(posedge Clock); while (!hostCmdReady);
		hostCmdValid <= 1'b0;
		if (e.cmd == oramPkg::cmdWrite) begin
			hostDataIn <= e.w0;
			hostDataInValid <= 1'b1;
			do @(posedge Clock); while (!hostDataInReady);
			hostDataIn <= e.w1;
			do @(posedge Clock); while (!hostDataInReady);
			hostDataInValid <= 1'b0;
			shadow[e.addr] = {e.w1, e.w0};
		end else begin
			// Words come low first and hold under back-pressure
			while (idx < oramPkg::BlockWords) begin
				@(posedge Clock);
				if (hostDataOutValid) begin
					if (held) begin
						checkWord("hostDataOut", hostDataOut, heldWord);
					end
					if (hostDataOutReady) begin
						checkWord("hostDataOut", hostDataOut,
							expBlock[idx*oramPkg::FEDWidth +: oramPkg::FEDWidth]);
						idx++;
						held = 1'b0;
					end else begin
						held = 1'b1;
						heldWord = hostDataOut;
					end
				end else if (held) begin
					failRun("hostDataOutValid dropped before the word was accepted");
				end
			end
			if (e.cmd == oramPkg::cmdReadRemove) begin
				shadow[e.addr] = '0;
			end
		end
		// No extra word may follow during write-back
		do begin
			@(posedge Clock);
			checkFlag("hostDataOutValid", hostDataOutValid, 1'b0);
		end while (!hostCmdReady);
	endtask

	// Host keeps offering a command that must never be taken
	task automatic runTrafficGen();
		hostCmd <= '{cmd: oramPkg::cmdRead, pAddr: '0};
		hostCmdValid <= 1'b1;
		modeTrafficGen <= 1'b1;
		do begin
			@(posedge Clock);
			checkFlag("hostCmdReady", hostCmdReady, 1'b0);
			checkFlag("patternError", patternError, 1'b0);
		end while (!patternDone);
		hostCmdValid <= 1'b0;
		// Done stays up while the last write-back drains
		do begin
			@(posedge Clock);
			checkFlag("hostCmdReady", hostCmdReady, 1'b0);
			checkFlag("patternDone", patternDone, 1'b1);
			checkFlag("patternError", patternError, 1'b0);
		end while (dramCmdValid || dramWriteValid);
	endtask

	// ------------------------------------------------------------------------
	// Stalls, watchdog, main sequence
	// ------------------------------------------------------------------------

	// Host ready about half the time and DRAM stalls about a quarter
	always @(posedge Clock) begin
		hostDataOutReady <= randomBits(1) != 32'd0;
		dramStall <= randomBits(2) == 32'd3;
	end

	always @(posedge Clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles) begin
			failRun($sformatf("timeout after %0d cycles, DUT stopped responding", cycleCount));
		end
	end

	initial begin
		hostCmd = '0;
		hostCmdValid = 1'b0;
		hostDataIn = '0;
		hostDataInValid = 1'b0;
		hostDataOutReady = 1'b0;
		modeTrafficGen = 1'b0;
		dramStall = 1'b0;
		for (int a = 0; a < NumBlocks; a++) begin
			shadow[a] = '0;
		end
		// Host stays above the generator range
		setEntry(0, 1'b0, oramPkg::cmdWrite, 10'h040);
		setEntry(1, 1'b0, oramPkg::cmdRead, 10'h040);
		setEntry(2, 1'b0, oramPkg::cmdRead, 10'h123);
		setEntry(3, 1'b0, oramPkg::cmdWrite, 10'h2AA);
		setEntry(4, 1'b0, oramPkg::cmdReadRemove, 10'h2AA);
		setEntry(5, 1'b0, oramPkg::cmdRead, 10'h2AA);
		setEntry(6, 1'b0, oramPkg::cmdWrite, 10'h3FF);
		setEntry(7, 1'b0, oramPkg::cmdWrite, 10'h040);
		setEntry(8, 1'b0, oramPkg::cmdRead, 10'h040);
		setEntry(9, 1'b0, oramPkg::cmdRead, 10'h3FF);
		setEntry(10, 1'b0, oramPkg::cmdReadRemove, 10'h3FF);
		setEntry(11, 1'b0, oramPkg::cmdRead, 10'h3FF);
		setEntry(12, 1'b1, oramPkg::cmdRead, 10'h000);

		@(posedge Clock);
		while (!rstN) @(posedge Clock);
		checkFlag("dramCmdValid", dramCmdValid, 1'b0);
		checkFlag("dramWriteValid", dramWriteValid, 1'b0);
		checkFlag("hostDataOutValid", hostDataOutValid, 1'b0);
		checkFlag("patternDone", patternDone, 1'b0);
		checkFlag("patternError", patternError, 1'b0);
		do @(posedge Clock); while (!hostCmdReady);

		for (int i = 0; i < NumEntries; i++) begin
			if (stimTable[i].mode) begin
				runTrafficGen();
			end else begin
				hostAccess(stimTable[i]);
			end
		end

		// Generator range holds the pattern and the rest follows the shadow
		for (int a = 0; a < NumBlocks; a++) begin
			if (a < oramPkg::TGenBlocks) begin
				checkBlock(a, dram.mem[a], patternBlock(a));
			end else begin
				checkBlock(a, dram.mem[a], shadow[a]);
			end
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule

//--- test/dramModel.sv
/* Behavioral DRAM for the block store testbench
   One block per beat, fixed read latency, command-ready stall from outside */

`timescale 1ns/1ps

module dramModel (
	input  logic                            Clock,
	input  logic                            rstN,
	input  logic                            stall,
	input  dramPkg::dramCmd                 cmd,
	input  logic                            cmdValid,
	output logic                            cmdReady,
	output logic [dramPkg::BEDWidth-1:0]    readData,
	output logic                            readDataValid,
	input  dramPkg::dramWrite               writeIn,
	input  logic                            writeValid,
	output logic                            writeReady
);

	localparam int Depth = 1024;

	logic [dramPkg::BEDWidth-1:0]       mem [Depth];
	// Read valid travels three stages
	logic [2:0]                         readPipe;
	logic [oramPkg::ORAMU-1:0]          readIdx;
	// Write command and beat may come in either order
	logic                               addrPend;
	logic                               dataPend;
	logic [oramPkg::ORAMU-1:0]          pendIdx;
	dramPkg::dramWrite                  pendWrite;
	logic                               readFire;
	logic                               wCmdFire;
	logic                               wDataFire;
	logic [oramPkg::ORAMU-1:0]          cmdIdx;
	logic [oramPkg::ORAMU-1:0]          wIdx;
	dramPkg::dramWrite                  wBeat;

	assign cmdReady   = !stall;
	assign writeReady = 1'b1;
	assign cmdIdx     = oramPkg::ORAMU'(cmd.addr >> dramPkg::BlockShift);
	assign readFire   = cmdValid && cmdReady && (cmd.command == dramPkg::ddrRead);
	assign wCmdFire   = cmdValid && cmdReady && (cmd.command == dramPkg::ddrWrite);
	assign wDataFire  = writeValid && writeReady;
	assign wIdx       = wCmdFire ? cmdIdx : pendIdx;
	assign wBeat      = wDataFire ? writeIn : pendWrite;

	assign readDataValid = readPipe[2];
	assign readData      = mem[readIdx];

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			readPipe <= '0;
			readIdx <= '0;
			addrPend <= 1'b0;
			dataPend <= 1'b0;
			pendIdx <= '0;
			pendWrite <= '0;
			for (int i = 0; i < Depth; i++) begin
				mem[i] <= '0;
			end
		end else begin
			readPipe <= {readPipe[1:0], readFire};
			if (readFire) begin
				readIdx <= cmdIdx;
			end
			// Commit once both halves of the write are in
			if ((addrPend || wCmdFire) && (dataPend || wDataFire)) begin
				for (int b = 0; b < dramPkg::DDRMWidth; b++) begin
					if (wBeat.mask[b]) begin
						mem[wIdx][8*b +: 8] <= wBeat.data[8*b +: 8];
					end
				end
				addrPend <= 1'b0;
				dataPend <= 1'b0;
			end else begin
				if (wCmdFire) begin
					addrPend <= 1'b1;
					pendIdx <= cmdIdx;
				end
				if (wDataFire) begin
					dataPend <= 1'b1;
					pendWrite <= writeIn;
				end
			end
		end
	end

endmodule

//--- test/clockGen.sv
/* Testbench clock and reset source
   100 ns clock, reset held low for the first two cycles */

`timescale 1ns/1ps

module clockGen (
	output logic Clock,
	output logic rstN
);

	localparam int HalfPeriod = 50;
	localparam int ResetCycles = 2;

	initial begin
		Clock = 1'b0;
		forever #HalfPeriod Clock = ~Clock;
	end

	// Release lands on a rising edge, after the flops sampled it low
	initial begin
		rstN = 1'b0;
		repeat (ResetCycles) @(posedge Clock);
		rstN <= 1'b1;
	end

endmodule

//--- logic/tinyOramWrap.sv
/* Block store top level
   Host port or traffic generator steered into one DRAM-backed core */

`timescale 1ns/1ps

module tinyOramWrap (
	input  logic                            Clock,
	input  logic                            rstN,

	input  oramPkg::oramCmd                 hostCmd,
	input  logic                            hostCmdValid,
	output logic                            hostCmdReady,
	input  logic [oramPkg::FEDWidth-1:0]    hostDataIn,
	input  logic                            hostDataInValid,
	output logic                            hostDataInReady,
	output logic [oramPkg::FEDWidth-1:0]    hostDataOut,
	output logic                            hostDataOutValid,
	input  logic                            hostDataOutReady,

	input  logic                            modeTrafficGen,

	output dramPkg::dramCmd                 dramCmdOut,
	output logic                            dramCmdValid,
	input  logic                            dramCmdReady,
	input  logic [dramPkg::BEDWidth-1:0]    dramReadData,
	input  logic                            dramReadDataValid,
	output dramPkg::dramWrite               dramWriteOut,
	output logic                            dramWriteValid,
	input  logic                            dramWriteReady,

	output logic                            patternDone,
	output logic                            patternError
);

	// Generator side of the steering
	oramPkg::oramCmd                    genCmd;
	logic                               genCmdValid;
	logic                               genCmdReady;
	logic [oramPkg::FEDWidth-1:0]       genDataIn;
	logic                               genDataInValid;
	logic                               genDataInReady;
	logic [oramPkg::FEDWidth-1:0]       genDataOut;
	logic                               genDataOutValid;
	logic                               genDataOutReady;

	// Core side of the steering
	oramPkg::oramCmd                    coreCmd;
	logic                               coreCmdValid;
	logic                               coreCmdReady;
	logic [oramPkg::FEDWidth-1:0]       coreDataIn;
	logic                               coreDataInValid;
	logic                               coreDataInReady;
	logic [oramPkg::FEDWidth-1:0]       coreDataOut;
	logic                               coreDataOutValid;
	logic                               coreDataOutReady;

	// ------------------------------------------------------------------------
	// Generator, steering, core
	// ------------------------------------------------------------------------

	// Starts as soon as its mode is selected
	trafficGen tGen (
		.Clock(Clock), .rstN(rstN), .enable(modeTrafficGen),
		.cmd(genCmd), .cmdValid(genCmdValid), .cmdReady(genCmdReady),
		.dataIn(genDataIn), .dataInValid(genDataInValid), .dataInReady(genDataInReady),
		.dataOut(genDataOut), .dataOutValid(genDataOutValid), .dataOutReady(genDataOutReady),
		.patternDone(patternDone), .patternError(patternError)
	);

	modeSelect steer (
		.hostCmd(hostCmd), .hostCmdValid(hostCmdValid), .hostCmdReady(hostCmdReady),
		.hostDataIn(hostDataIn), .hostDataInValid(hostDataInValid),
		.hostDataInReady(hostDataInReady),
		.hostDataOut(hostDataOut), .hostDataOutValid(hostDataOutValid),
		.hostDataOutReady(hostDataOutReady),
		.genCmd(genCmd), .genCmdValid(genCmdValid), .genCmdReady(genCmdReady),
		.genDataIn(genDataIn), .genDataInValid(genDataInValid),
		.genDataInReady(genDataInReady),
		.genDataOut(genDataOut), .genDataOutValid(genDataOutValid),
		.genDataOutReady(genDataOutReady),
		.coreCmd(coreCmd), .coreCmdValid(coreCmdValid), .coreCmdReady(coreCmdReady),
		.coreDataIn(coreDataIn), .coreDataInValid(coreDataInValid),
		.coreDataInReady(coreDataInReady),
		.coreDataOut(coreDataOut), .coreDataOutValid(coreDataOutValid),
		.coreDataOutReady(coreDataOutReady),
		.modeTrafficGen(modeTrafficGen)
	);

	blockCore core (
		.Clock(Clock), .rstN(rstN),
		.cmd(coreCmd), .cmdValid(coreCmdValid), .cmdReady(coreCmdReady),
		.dataIn(coreDataIn), .dataInValid(coreDataInValid), .dataInReady(coreDataInReady),
		.dataOut(coreDataOut), .dataOutValid(coreDataOutValid),
		.dataOutReady(coreDataOutReady),
		.dramCmdOut(dramCmdOut), .dramCmdValid(dramCmdValid), .dramCmdReady(dramCmdReady),
		.dramReadData(dramReadData), .dramReadDataValid(dramReadDataValid),
		.dramWriteOut(dramWriteOut), .dramWriteValid(dramWriteValid),
		.dramWriteReady(dramWriteReady)
	);

endmodule

//--- logic/blockCore.sv
/* Block access core
   Every host command becomes one DRAM read and one full-block write-back */

`timescale 1ns/1ps

module blockCore (
	input  logic                            Clock,
	input  logic                            rstN,

	input  oramPkg::oramCmd                 cmd,
	input  logic                            cmdValid,
	output logic                            cmdReady,

	input  logic [oramPkg::FEDWidth-1:0]    dataIn,
	input  logic                            dataInValid,
	output logic                            dataInReady,

	output logic [oramPkg::FEDWidth-1:0]    dataOut,
	output logic                            dataOutValid,
	input  logic                            dataOutReady,

	output dramPkg::dramCmd                 dramCmdOut,
	output logic                            dramCmdValid,
	input  logic                            dramCmdReady,

	input  logic [dramPkg::BEDWidth-1:0]    dramReadData,
	input  logic                            dramReadDataValid,

	output dramPkg::dramWrite               dramWriteOut,
	output logic                            dramWriteValid,
	input  logic                            dramWriteReady
);

	typedef enum logic [2:0] {
		sInit,
		sIdle,
		sReadCmd,
		sReadWait,
		sHost,
		sWriteBack
	} stateE;

	stateE                              state;
	oramPkg::oramCmd                    curCmd;
	// Fetched block, word 0 in the low half
	logic [oramPkg::BlockWords-1:0][oramPkg::FEDWidth-1:0] blockR;
	logic [oramPkg::WordIdxWidth-1:0]   wordIdx;
	// Write-back halves that already went out
	logic                               cmdDone;
	logic                               dataDone;

	logic                               isWrite;
	logic                               cmdFire;
	logic                               dataInFire;
	logic                               dataOutFire;
	logic                               dramCmdFire;
	logic                               dramWriteFire;
	logic                               lastWord;
	logic                               wbFinished;

	// ------------------------------------------------------------------------
	// Handshakes
	// ------------------------------------------------------------------------

	assign isWrite  = (curCmd.cmd == oramPkg::cmdWrite);
	assign lastWord = (wordIdx == oramPkg::LastWord);

	// Idle only, and not in the first cycle out of reset
	assign cmdReady     = (state == sIdle);
	assign dataInReady  = (state == sHost) && isWrite;
	assign dataOutValid = (state == sHost) && !isWrite;
	assign dataOut      = blockR[wordIdx];

	assign dramCmdValid = (state == sReadCmd) || ((state == sWriteBack) && !cmdDone);
	assign dramCmdOut.addr = dramPkg::ddrAddrT'(curCmd.pAddr) << dramPkg::BlockShift;
	assign dramCmdOut.command = (state == sWriteBack) ? dramPkg::ddrWrite : dramPkg::ddrRead;

	// Whole block always goes back
	assign dramWriteValid     = (state == sWriteBack) && !dataDone;
	assign dramWriteOut.data  = blockR;
	assign dramWriteOut.mask  = '1;

	assign cmdFire       = cmdValid && cmdReady;
	assign dataInFire    = dataInValid && dataInReady;
	assign dataOutFire   = dataOutValid && dataOutReady;
	assign dramCmdFire   = dramCmdValid && dramCmdReady;
	assign dramWriteFire = dramWriteValid && dramWriteReady;

	// Command and data may land in either order
	assign wbFinished = (cmdDone || dramCmdFire) && (dataDone || dramWriteFire);

	// ------------------------------------------------------------------------
	// Control FSM
	// ------------------------------------------------------------------------

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			state <= sInit;
			wordIdx <= '0;
			cmdDone <= 1'b0;
			dataDone <= 1'b0;
		end else begin
			case (state)
				sInit: state <= sIdle;
				sIdle: begin
					if (cmdFire) begin
						state <= sReadCmd;
					end
				end
				sReadCmd: begin
					if (dramCmdFire) begin
						state <= sReadWait;
					end
				end
				// Latency is up to the memory
				sReadWait: begin
					if (dramReadDataValid) begin
						state <= sHost;
					end
				end
				sHost: begin
					if (dataInFire || dataOutFire) begin
						wordIdx <= wordIdx + 1'b1;
						if (lastWord) begin
							wordIdx <= '0;
							state <= sWriteBack;
						end
					end
				end
				sWriteBack: begin
					if (dramCmdFire) begin
						cmdDone <= 1'b1;
					end
					if (dramWriteFire) begin
						dataDone <= 1'b1;
					end
					if (wbFinished) begin
						cmdDone <= 1'b0;
						dataDone <= 1'b0;
						state <= sIdle;
					end
				end
				default: state <= sIdle;
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// Payload
	// ------------------------------------------------------------------------

	always_ff @(posedge Clock) begin
		if (cmdFire) begin
			curCmd <= cmd;
		end
		if ((state == sReadWait) && dramReadDataValid) begin
			blockR <= dramReadData;
		end else if (dataInFire) begin
			blockR[wordIdx] <= dataIn;
		end else if (dataOutFire && lastWord && (curCmd.cmd == oramPkg::cmdReadRemove)) begin
			// Remove writes back an empty block
			blockR <= '0;
		end
	end

	// Write access shows no read data until the core is idle again
	noOutOnWrite: assert property (@(posedge Clock) disable iff (!rstN)
		cmdFire && (cmd.cmd == oramPkg::cmdWrite) |=> (!dataOutValid until cmdReady));

	// Memory answers only the read just issued
	strobeInWait: assert property (@(posedge Clock) disable iff (!rstN)
		dramReadDataValid |-> (state == sReadWait));

endmodule

//--- logic/trafficGen.sv
/* Built-in traffic generator
   Writes a known pattern over a block range, reads it back, flags mismatches */

`timescale 1ns/1ps

module trafficGen (
	input  logic                            Clock,
	input  logic                            rstN,
	input  logic                            enable,

	output oramPkg::oramCmd                 cmd,
	output logic                            cmdValid,
	input  logic                            cmdReady,

	output logic [oramPkg::FEDWidth-1:0]    dataIn,
	output logic                            dataInValid,
	input  logic                            dataInReady,

	input  logic [oramPkg::FEDWidth-1:0]    dataOut,
	input  logic                            dataOutValid,
	output logic                            dataOutReady,

	output logic                            patternDone,
	output logic                            patternError
);

	typedef enum logic [1:0] {
		sIdle,
		sCmd,
		sData,
		sDone
	} stateE;

	stateE                              state;
	// High during the write sweep, low during readback
	logic                               writing;
	logic [oramPkg::ORAMU-1:0]          addr;
	logic [oramPkg::WordIdxWidth-1:0]   wordIdx;
	logic                               beat;
	logic [oramPkg::FEDWidth-1:0]       expected;

	// Upper half is the address, lower half its inverse with bit 0 flipped by k
	function automatic logic [oramPkg::FEDWidth-1:0] patternWord(
		input logic [oramPkg::ORAMU-1:0]        a,
		input logic [oramPkg::WordIdxWidth-1:0] k
	);
		logic [oramPkg::FEDWidth/2-1:0] hi;
		logic [oramPkg::FEDWidth/2-1:0] lo;
		hi = a;
		lo = ~hi;
		lo[0] = lo[0] ^ k[0];
		return {hi, lo};
	endfunction

	assign expected = patternWord(addr, wordIdx);

	assign cmd.cmd     = writing ? oramPkg::cmdWrite : oramPkg::cmdRead;
	assign cmd.pAddr   = addr;
	assign cmdValid    = (state == sCmd);
	assign dataIn      = expected;
	assign dataInValid = (state == sData) && writing;
	// Read data is always taken at once
	assign dataOutReady = 1'b1;
	assign patternDone  = (state == sDone);

	// One word moved in either phase
	assign beat = (state == sData) &&
		(writing ? dataInReady : dataOutValid);

	// ------------------------------------------------------------------------
	// Sequencer
	// ------------------------------------------------------------------------

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			state <= sIdle;
			writing <= 1'b1;
			addr <= '0;
			wordIdx <= '0;
			patternError <= 1'b0;
		end else begin
			// Sticky on first bad word
			if (beat && !writing && (dataOut != expected)) begin
				patternError <= 1'b1;
			end
			case (state)
				sIdle: begin
					if (enable) begin
						state <= sCmd;
					end
				end
				sCmd: begin
					if (cmdReady) begin
						state <= sData;
					end
				end
				sData: begin
					if (beat) begin
						wordIdx <= wordIdx + 1'b1;
						if (wordIdx == oramPkg::LastWord) begin
							wordIdx <= '0;
							state <= sCmd;
							addr <= addr + 1'b1;
							if (addr == oramPkg::TGenLastAddr) begin
								// Wrap to readback, or stop after it
								addr <= '0;
								writing <= 1'b0;
								if (!writing) begin
									state <= sDone;
								end
							end
						end
					end
				end
				default: state <= sDone;
			endcase
		end
	end

	// Offered command stays up and unchanged until taken
	cmdHeld: assert property (@(posedge Clock) disable iff (!rstN)
		cmdValid && !cmdReady |=> cmdValid && $stable(cmd));

endmodule

//--- logic/modeSelect.sv
/* Channel steering between host, traffic generator and core
   Exactly one side owns the core's handshakes at a time */

`timescale 1ns/1ps

module modeSelect (
	input  oramPkg::oramCmd                 hostCmd,
	input  logic                            hostCmdValid,
	output logic                            hostCmdReady,
	input  logic [oramPkg::FEDWidth-1:0]    hostDataIn,
	input  logic                            hostDataInValid,
	output logic                            hostDataInReady,
	output logic [oramPkg::FEDWidth-1:0]    hostDataOut,
	output logic                            hostDataOutValid,
	input  logic                            hostDataOutReady,

	input  oramPkg::oramCmd                 genCmd,
	input  logic                            genCmdValid,
	output logic                            genCmdReady,
	input  logic [oramPkg::FEDWidth-1:0]    genDataIn,
	input  logic                            genDataInValid,
	output logic                            genDataInReady,
	output logic [oramPkg::FEDWidth-1:0]    genDataOut,
	output logic                            genDataOutValid,
	input  logic                            genDataOutReady,

	output oramPkg::oramCmd                 coreCmd,
	output logic                            coreCmdValid,
	input  logic                            coreCmdReady,
	output logic [oramPkg::FEDWidth-1:0]    coreDataIn,
	output logic                            coreDataInValid,
	input  logic                            coreDataInReady,
	input  logic [oramPkg::FEDWidth-1:0]    coreDataOut,
	input  logic                            coreDataOutValid,
	output logic                            coreDataOutReady,

	input  logic                            modeTrafficGen
);

	// Requests into the core, picked by owner
	assign coreCmd          = modeTrafficGen ? genCmd : hostCmd;
	assign coreCmdValid     = modeTrafficGen ? genCmdValid : hostCmdValid;
	assign coreDataIn       = modeTrafficGen ? genDataIn : hostDataIn;
	assign coreDataInValid  = modeTrafficGen ? genDataInValid : hostDataInValid;
	assign coreDataOutReady = modeTrafficGen ? genDataOutReady : hostDataOutReady;

	// Responses gated so the idle side sees nothing
	assign hostCmdReady     = !modeTrafficGen && coreCmdReady;
	assign hostDataInReady  = !modeTrafficGen && coreDataInReady;
	assign hostDataOutValid = !modeTrafficGen && coreDataOutValid;
	assign genCmdReady      = modeTrafficGen && coreCmdReady;
	assign genDataInReady   = modeTrafficGen && coreDataInReady;
	assign genDataOutValid  = modeTrafficGen && coreDataOutValid;

	// Read data fans out to both sides
	assign hostDataOut = coreDataOut;
	assign genDataOut  = coreDataOut;

endmodule

//--- logic/dramPkg.sv
/* DRAM-side definitions for the block store
   Command codes, beat and address widths, command and write structs */

package dramPkg;

	// One beat carries a whole block
	localparam int BEDWidth = 64;
	// Byte address and byte mask
	localparam int DDRAWidth = 16;
	localparam int DDRMWidth = BEDWidth / 8;
	// Block address to byte address
	localparam int BlockShift = $clog2(DDRMWidth);

	typedef logic [DDRAWidth-1:0] ddrAddrT;

	typedef enum logic {
		ddrRead  = 1'b0,
		ddrWrite = 1'b1
	} dramCmdE;

	typedef struct packed {
		ddrAddrT addr;
		dramCmdE command;
	} dramCmd;

	// Mask bit set means byte written
	typedef struct packed {
		logic [BEDWidth-1:0]  data;
		logic [DDRMWidth-1:0] mask;
	} dramWrite;

endpackage

//--- logic/oramPkg.sv
/* Host-side definitions for the block store
   Command encoding, front-end widths and the command struct */

package oramPkg;

	// ------------------------------------------------------------------------
	// Front-end sizes
	// ------------------------------------------------------------------------

	// One host data word
	localparam int FEDWidth = 32;
	// Host words per block, low word first
	localparam int BlockWords = 2;
	localparam int WordIdxWidth = $clog2(BlockWords);
	localparam logic [WordIdxWidth-1:0] LastWord = WordIdxWidth'(BlockWords - 1);

	// Block address width
	localparam int ORAMU = 10;

	// Traffic generator covers blocks 0 .. TGenBlocks-1
	localparam int TGenBlocks = 16;
	localparam logic [ORAMU-1:0] TGenLastAddr = ORAMU'(TGenBlocks - 1);

	// ------------------------------------------------------------------------
	// Commands
	// ------------------------------------------------------------------------

	// Every command costs one DRAM read and one DRAM write
	typedef enum logic [1:0] {
		cmdRead       = 2'd0,
		cmdWrite      = 2'd1,
		cmdReadRemove = 2'd2
	} cmdE;

	typedef struct packed {
		cmdE              cmd;
		logic [ORAMU-1:0] pAddr;
	} oramCmd;

endpackage
